// ==== verilog/qspi_sram_pkg.sv ====
package qspi_sram_pkg;

	// byte level operations the sequencer hands to the phy
	typedef enum logic [1:0] {
		OP_GAP   = 2'd0,                            // one spi clock, no data, sck held low
		OP_SEND1 = 2'd1,                            // 8 bits msb first on lane 0
		OP_SEND4 = 2'd2,                            // one byte on four lanes, high nibble first
		OP_RECV4 = 2'd3                             // one byte sampled on four lanes
	} op_t;

	// sram opcodes
	localparam logic [7:0] CMD_QUAD_ENTER = 8'h38;  // enter sqi mode, sent single lane
	localparam logic [7:0] CMD_WRITE      = 8'h02;  // sequential write
	localparam logic [7:0] CMD_READ       = 8'h03;  // sequential read, dummy byte follows address

	// four phases per spi clock, sck high in phases 2 and 3
	localparam logic [1:0] PH_DRIVE  = 2'd1;        // lanes change on entry to this phase
	localparam logic [1:0] PH_SAMPLE = 2'd3;        // lanes sampled on entry to this phase

	// spi clocks with cs_n high after each burst
	localparam int HANGUP_GAPS = 2;

endpackage

// ==== verilog/burst_buffer.sv ====
module burst_buffer #(
	parameter int FIFO_DEPTH = 32                   // entries, also the longest burst
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          user_push,  // user strobe, ignored while eng_own
	input  logic [7:0]                    user_wdata,
	input  logic                          user_pop,   // user strobe, ignored while eng_own
	output logic [7:0]                    user_rdata, // head byte, combinational
	input  logic                          eng_own,    // engine owns both ports for the burst
	input  logic                          eng_push,
	input  logic [7:0]                    eng_wdata,
	input  logic                          eng_pop,
	input  logic                          flush,      // drop everything buffered
	output logic [7:0]                    eng_rdata,
	output logic                          empty,
	output logic                          full,
	output logic [$clog2(FIFO_DEPTH):0]   count
);

	localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

	logic [7:0]    mem [FIFO_DEPTH];                // byte storage
	logic [AW-1:0] wptr;
	logic [AW-1:0] rptr;
	logic          push;                            // push request from current owner
	logic          pop;                             // pop request from current owner
	logic [7:0]    wdata;
	logic          do_push;
	logic          do_pop;

	// wrap explicitly so any depth works, not just powers of two
	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
		return (p == AW'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign push    = eng_own ? eng_push : user_push;  // ownership mux
	assign pop     = eng_own ? eng_pop : user_pop;
	assign wdata   = eng_own ? eng_wdata : user_wdata;
	assign do_push = push && !full;                 // overflow pushes are dropped
	assign do_pop  = pop && !empty;                 // underflow pops are ignored

	assign empty      = (count == '0);
	assign full       = (count == ($clog2(FIFO_DEPTH) + 1)'(FIFO_DEPTH));
	assign user_rdata = mem[rptr];                  // both sides see the same head
	assign eng_rdata  = mem[rptr];

	always_ff @(posedge clk) begin
		if (do_push && !flush) begin
			mem[wptr] <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wptr <= next_ptr(wptr);
			end
			if (do_pop) begin
				rptr <= next_ptr(rptr);
			end
			count <= count + do_push - do_pop;  // net change this cycle
		end
	end

	// the sequencer checks level before it moves data
	a_eng_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		eng_own && eng_push |-> !full);
	a_eng_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		eng_own && eng_pop |-> !empty);

endmodule

// ==== verilog/sram_sequencer.sv ====
module sram_sequencer import qspi_sram_pkg::*; #(
	parameter int FIFO_DEPTH  = 32,
	parameter int ADDR_BYTES  = 2,
	parameter int DUMMY_BYTES = 1
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        write_cmd,  // one cycle strobe
	input  logic                        read_cmd,   // one cycle strobe
	input  logic [8*ADDR_BYTES-1:0]     address,
	input  logic [$clog2(FIFO_DEPTH):0] read_len,
	output logic                        busy,
	output logic                        eng_own,
	output logic                        eng_push,
	output logic [7:0]                  eng_wdata,
	output logic                        eng_pop,
	output logic                        flush,
	input  logic [7:0]                  eng_rdata,
	input  logic                        empty,
	output logic                        op_start,   // one cycle pulse to the phy
	output op_t                         op,
	output logic [7:0]                  tx_byte,
	output logic                        cs_active,  // level, phy turns it into cs_n
	input  logic                        op_done,
	input  logic [7:0]                  rx_byte     // valid with op_done
);

	localparam int AW = 8 * ADDR_BYTES;
	localparam int LW = $clog2(FIFO_DEPTH) + 1;
	localparam int CW = $clog2(FIFO_DEPTH + ADDR_BYTES + DUMMY_BYTES + HANGUP_GAPS) + 1;

	typedef enum logic [2:0] {
		S_LEAD,                                     // start gap with cs active
		S_IDLE,
		S_OPCODE,
		S_ADDR,
		S_DUMMY,
		S_DATA,
		S_HANGUP
	} state_t;

	state_t        state;
	logic [7:0]    cmd_r;                           // opcode of the running sequence
	logic [AW-1:0] addr_r;                          // shifts left as bytes go out
	logic [LW-1:0] len_r;                           // read length
	logic [CW-1:0] cnt;                             // bytes or gaps left in this state
	logic          waiting;                         // op in flight, wait for op_done
	logic          is_write;

	assign is_write = (cmd_r == CMD_WRITE);
	assign eng_own  = busy;                         // user side locked out until busy falls

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= S_LEAD;                    // init runs straight out of reset
			cmd_r     <= CMD_QUAD_ENTER;
			addr_r    <= '0;
			len_r     <= '0;
			cnt       <= '0;
			waiting   <= 1'b0;
			busy      <= 1'b1;
			cs_active <= 1'b0;
			op_start  <= 1'b0;
			op        <= OP_GAP;
			eng_push  <= 1'b0;
			eng_pop   <= 1'b0;
			flush     <= 1'b0;
		end else begin
			op_start <= 1'b0;                       // strobes default low
			eng_push <= 1'b0;
			eng_pop  <= 1'b0;
			flush    <= 1'b0;
			if (waiting) begin
				if (op_done) begin              // advance once the phy finishes
					waiting <= 1'b0;
					case (state)
						S_LEAD: state <= S_OPCODE;
						S_OPCODE: begin
							if (cmd_r == CMD_QUAD_ENTER) begin
								state <= S_HANGUP;  // init ends after 0x38
								cnt   <= CW'(HANGUP_GAPS);
							end else begin
								state <= S_ADDR;
								cnt   <= CW'(ADDR_BYTES);
							end
						end
						S_ADDR: begin
							cnt <= cnt - 1'b1;
							if (cnt == CW'(1)) begin
								if (is_write) begin
									state <= S_DATA;
								end else if (DUMMY_BYTES > 0) begin
									state <= S_DUMMY;
									cnt   <= CW'(DUMMY_BYTES);
								end else begin
									state <= S_DATA;
									cnt   <= CW'(len_r);
								end
							end
						end
						S_DUMMY: begin
							cnt <= cnt - 1'b1;      // byte discarded
							if (cnt == CW'(1)) begin
								state <= S_DATA;
								cnt   <= CW'(len_r);
							end
						end
						S_DATA: begin
							if (!is_write) begin
								eng_push  <= 1'b1;  // read byte into buffer
								eng_wdata <= rx_byte;
								cnt       <= cnt - 1'b1;
								if (cnt == CW'(1)) begin
									state <= S_HANGUP;
									cnt   <= CW'(HANGUP_GAPS);
								end
							end
						end
						S_HANGUP: begin
							cnt <= cnt - 1'b1;
							if (cnt == CW'(1)) begin
								state <= S_IDLE;
								busy  <= 1'b0;  // burst over
							end
						end
						default: state <= S_IDLE;
					endcase
				end
			end else begin
				case (state)
					S_IDLE: begin
						if (write_cmd || read_cmd) begin
							cmd_r  <= write_cmd ? CMD_WRITE : CMD_READ;  // write wins
							addr_r <= address;
							busy   <= 1'b1;
							state  <= S_LEAD;
							if (!write_cmd) begin
								len_r <= read_len;
								flush <= 1'b1;      // stale bytes out before reading
							end
						end
					end
					S_LEAD: begin
						op        <= OP_GAP;
						cs_active <= 1'b1;          // select ahead of the first clock
						op_start  <= 1'b1;
						waiting   <= 1'b1;
					end
					S_OPCODE: begin
						op       <= (cmd_r == CMD_QUAD_ENTER) ? OP_SEND1 : OP_SEND4;
						tx_byte  <= cmd_r;
						op_start <= 1'b1;
						waiting  <= 1'b1;
					end
					S_ADDR: begin
						op       <= OP_SEND4;
						tx_byte  <= addr_r[AW-1 -: 8];  // msb first
						addr_r   <= addr_r << 8;
						op_start <= 1'b1;
						waiting  <= 1'b1;
					end
					S_DUMMY: begin
						op       <= OP_RECV4;
						op_start <= 1'b1;
						waiting  <= 1'b1;
					end
					S_DATA: begin
						if (!is_write) begin
							op       <= OP_RECV4;
							op_start <= 1'b1;
							waiting  <= 1'b1;
						end else if (!empty) begin
							op       <= OP_SEND4;
							tx_byte  <= eng_rdata;  // head byte goes out
							eng_pop  <= 1'b1;
							op_start <= 1'b1;
							waiting  <= 1'b1;
						end else begin
							state <= S_HANGUP;      // buffer drained
							cnt   <= CW'(HANGUP_GAPS);
						end
					end
					S_HANGUP: begin
						op        <= OP_GAP;
						cs_active <= 1'b0;          // deselect for the gaps
						op_start  <= 1'b1;
						waiting   <= 1'b1;
					end
					default: state <= S_IDLE;
				endcase
			end
		end
	end

	// read bursts must fit the buffer since there is no back-pressure
	a_read_len_range: assert property (@(posedge clk) disable iff (!rst_n)
		(state == S_IDLE) && !waiting && read_cmd && !write_cmd |->
		(read_len >= 1) && (read_len <= FIFO_DEPTH));

endmodule

// ==== verilog/qspi_phy.sv ====
module qspi_phy import qspi_sram_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [15:0] bauddiv,                    // clk cycles per phase, minus one
	input  logic        op_start,
	input  op_t         op,
	input  logic [7:0]  tx_byte,
	input  logic        cs_active,
	output logic        op_done,                    // one cycle after the last sample edge
	output logic [7:0]  rx_byte,
	output logic        sck,
	output logic        cs_n,
	inout  wire  [3:0]  sio
);

	logic        running;                           // op in progress
	op_t         op_r;
	logic [15:0] timer;                             // counts down to the next phase
	logic [1:0]  phase;
	logic [1:0]  next_phase;
	logic [3:0]  units;                             // bits or nibbles or gaps left
	logic [7:0]  shreg;                             // tx shifts out, rx shifts in
	logic [3:0]  dout;
	logic [3:0]  oe;                                // per lane output enable
	logic        tick;
	logic        drive_edge;
	logic        sample_edge;

	assign next_phase  = phase + 2'd1;
	assign tick        = running && (timer == 16'd0);
	assign drive_edge  = tick && (next_phase == PH_DRIVE);
	assign sample_edge = tick && (next_phase == PH_SAMPLE);

	for (genvar i = 0; i < 4; i++) begin : g_lane
		assign sio[i] = oe[i] ? dout[i] : 1'bz; // released lanes float to the pullups
	end

	// phase timer, holds between ops so sck keeps its level
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			timer <= bauddiv;
			phase <= 2'd3;                      // first tick enters phase 0
		end else if (!running) begin
			timer <= bauddiv;
		end else if (timer == 16'd0) begin
			timer <= bauddiv;
			phase <= next_phase;
		end else begin
			timer <= timer - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sck  <= 1'b0;
			cs_n <= 1'b1;
		end else begin
			if (tick) begin
				sck <= next_phase[1] && (op_r != OP_GAP);  // gaps never clock the device
			end
			if (drive_edge) begin
				cs_n <= ~cs_active;         // cs moves while sck is low
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			running <= 1'b0;
			op_r    <= OP_GAP;
			units   <= '0;
			op_done <= 1'b0;
			oe      <= 4'b0000;
		end else begin
			op_done <= 1'b0;
			if (op_start) begin
				running <= 1'b1;
				op_r    <= op;
				case (op)
					OP_SEND1: units <= 4'd8;
					OP_GAP:   units <= 4'd1;
					default:  units <= 4'd2;    // two nibbles
				endcase
			end else if (sample_edge) begin
				units <= units - 1'b1;
				if (units == 4'd1) begin
					running <= 1'b0;
					op_done <= 1'b1;
					oe      <= 4'b0000;     // release at the end of every op
				end
			end
			if (drive_edge) begin
				case (op_r)
					OP_SEND1: oe <= 4'b0001;    // si only
					OP_SEND4: oe <= 4'b1111;
					OP_RECV4: oe <= 4'b0000;    // device drives
					default:  oe <= oe;
				endcase
			end
		end
	end

	// shifter, payload only
	always_ff @(posedge clk) begin
		if (op_start) begin
			shreg <= tx_byte;
		end else if (drive_edge && op_r == OP_SEND1) begin
			dout  <= {3'b000, shreg[7]};
			shreg <= {shreg[6:0], 1'b0};
		end else if (drive_edge && op_r == OP_SEND4) begin
			dout  <= shreg[7:4];                // high nibble first
			shreg <= {shreg[3:0], 4'h0};
		end else if (sample_edge && op_r == OP_RECV4) begin
			shreg <= {shreg[3:0], sio};
			if (units == 4'd1) begin
				rx_byte <= {shreg[3:0], sio};
			end
		end
	end

	// sequencer waits for op_done before the next op
	a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		op_start |-> !running);
	// lanes stay released whenever the device is deselected
	a_no_drive_deselected: assert property (@(posedge clk) disable iff (!rst_n)
		cs_n |-> (oe == 4'b0000));

endmodule

// ==== verilog/qspi_sram_ctrl.sv ====
module qspi_sram_ctrl import qspi_sram_pkg::*; #(
	parameter int FIFO_DEPTH  = 32,                 // buffer entries and longest burst
	parameter int ADDR_BYTES  = 2,                  // 2 for a 64 KiB part
	parameter int DUMMY_BYTES = 1                   // bytes dropped after a read address
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [15:0]                 bauddiv,
	input  logic [7:0]                  data_in,
	input  logic                        data_push,
	input  logic                        data_pop,
	input  logic                        write_cmd,
	input  logic                        read_cmd,
	input  logic [8*ADDR_BYTES-1:0]     address,
	input  logic [$clog2(FIFO_DEPTH):0] read_len,
	output logic [7:0]                  data_out,
	output logic                        data_empty,
	output logic                        busy,
	output logic                        sck,
	output logic                        cs_n,
	inout  wire  [3:0]                  sio
);

	// buffer to sequencer
	logic       eng_own;
	logic       eng_push;
	logic [7:0] eng_wdata;
	logic       eng_pop;
	logic       flush;
	logic [7:0] eng_rdata;

	// sequencer to phy
	logic       op_start;
	op_t        op;
	logic [7:0] tx_byte;
	logic       cs_active;
	logic       op_done;
	logic [7:0] rx_byte;

	burst_buffer #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_buffer (
		.clk        (clk),
		.rst_n      (rst_n),
		.user_push  (data_push),
		.user_wdata (data_in),
		.user_pop   (data_pop),
		.user_rdata (data_out),
		.eng_own    (eng_own),
		.eng_push   (eng_push),
		.eng_wdata  (eng_wdata),
		.eng_pop    (eng_pop),
		.flush      (flush),
		.eng_rdata  (eng_rdata),
		.empty      (data_empty),  // also the engine's drain check
		.full       (),
		.count      ()
	);

	sram_sequencer #(
		.FIFO_DEPTH  (FIFO_DEPTH),
		.ADDR_BYTES  (ADDR_BYTES),
		.DUMMY_BYTES (DUMMY_BYTES)
	) u_sequencer (
		.clk       (clk),
		.rst_n     (rst_n),
		.write_cmd (write_cmd),
		.read_cmd  (read_cmd),
		.address   (address),
		.read_len  (read_len),
		.busy      (busy),
		.eng_own   (eng_own),
		.eng_push  (eng_push),
		.eng_wdata (eng_wdata),
		.eng_pop   (eng_pop),
		.flush     (flush),
		.eng_rdata (eng_rdata),
		.empty     (data_empty),
		.op_start  (op_start),
		.op        (op),
		.tx_byte   (tx_byte),
		.cs_active (cs_active),
		.op_done   (op_done),
		.rx_byte   (rx_byte)
	);

	qspi_phy u_phy (
		.clk       (clk),
		.rst_n     (rst_n),
		.bauddiv   (bauddiv),
		.op_start  (op_start),
		.op        (op),
		.tx_byte   (tx_byte),
		.cs_active (cs_active),
		.op_done   (op_done),
		.rx_byte   (rx_byte),
		.sck       (sck),
		.cs_n      (cs_n),
		.sio       (sio)
	);

endmodule

// ==== verif/tb_clock_gen.sv ====
module tb_clock_gen #(
	parameter int PERIOD_NS    = 40,                // clk period
	parameter int RESET_CYCLES = 10                 // rising edges with rst_n low
) (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 rst_n = 1'b1;                            // released like any other input
	end

endmodule

// ==== verif/qspi_sram_model.sv ====
module qspi_sram_model import qspi_sram_pkg::*; (
	input  logic       sck,
	input  logic       cs_n,
	inout  wire  [3:0] sio,
	output logic       quad_mode,                   // set once 0x38 has been seen
	output int         spi_bytes,                   // single lane bytes received
	output logic [7:0] spi_byte,                    // last single lane byte
	output int         bursts,                      // cs_n falling edges
	output int         write_len,                   // data bytes of the last write burst
	output logic       error                        // illegal transfer seen
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HDR        = 6;                  // opcode plus two address bytes, in nibbles
	localparam int DATA_START = HDR + 2;            // one dummy byte before read data

	logic [7:0]  mem [65536];                       // 64 KiB array
	logic [7:0]  sh;                                // incoming shift register
	logic [7:0]  cmd;
	logic [15:0] addr;                              // burst start address
	logic [15:0] waddr;                             // running write address
	logic [7:0]  rbyte;
	logic [3:0]  drv;
	logic        drv_en;
	logic        sck_q;
	logic        cs_q;
	int          edges;                             // sck rising edges since select
	int          k;

	assign sio = drv_en ? drv : 4'bzzzz;

	initial begin
		quad_mode = 1'b0;
		spi_bytes = 0;
		spi_byte  = 8'h00;
		bursts    = 0;
		write_len = 0;
		error     = 1'b0;
		drv_en    = 1'b0;
		drv       = 4'h0;
		edges     = 0;
		cmd       = 8'h00;
		sh        = 8'h00;
		addr      = 16'h0000;
		waddr     = 16'h0000;
		sck_q     = 1'b0;
		cs_q      = 1'b1;
	end

	always @(sck or cs_n) begin
		if (cs_n !== cs_q) begin
			if (cs_n === 1'b0) begin                // select, new burst
				bursts++;
				edges = 0;
				cmd   = 8'h00;
			end else begin                          // deselect
				drv_en = 1'b0;
				if (!quad_mode && edges == 8 && spi_byte == CMD_QUAD_ENTER) begin
					quad_mode = 1'b1;
				end
				if (quad_mode && cmd == CMD_WRITE && edges >= HDR) begin
					write_len = (edges - HDR) / 2;
				end
			end
		end else if (cs_n === 1'b0 && sck === 1'b1 && sck_q === 1'b0) begin
			edges++;
			if (!quad_mode) begin
				sh = {sh[6:0], sio[0]};             // si on lane 0, msb first
				if (edges == 8) begin
					spi_bytes++;
					spi_byte = sh;
					if (sh != CMD_QUAD_ENTER) begin
						error = 1'b1;
						$display("memory model got single lane opcode %02h", sh);
					end
				end else if (edges > 8) begin
					error = 1'b1;
					$display("memory model got more than one byte in single lane mode");
				end
			end else begin
				sh = {sh[3:0], sio};                // nibble, high first
				if (edges == 2) begin
					cmd = sh;
					if (cmd != CMD_WRITE && cmd != CMD_READ) begin
						error = 1'b1;
						$display("memory model got unknown quad opcode %02h", cmd);
					end
				end else if (edges <= HDR && edges % 2 == 0) begin
					addr  = {addr[7:0], sh};        // msb first
					waddr = addr;
				end else if (edges > HDR && edges % 2 == 0 && cmd == CMD_WRITE) begin
					mem[waddr] = sh;
					waddr++;                        // wraps at 64 KiB
				end
			end
		end else if (cs_n === 1'b0 && sck === 1'b0 && sck_q === 1'b1) begin
			// read data changes on the falling edge, valid for the next high phase
			if (quad_mode && cmd == CMD_READ && edges >= DATA_START) begin
				k      = edges - DATA_START;
				rbyte  = mem[16'(addr + k / 2)];
				drv    = (k % 2 == 0) ? rbyte[7:4] : rbyte[3:0];
				drv_en = 1'b1;
			end
		end
		sck_q = sck;
		cs_q  = cs_n;
	end

endmodule

// ==== verif/tb_qspi_sram.sv ====
module tb_qspi_sram import qspi_sram_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int FIFO_DEPTH  = 32;
	localparam int ADDR_BYTES  = 2;
	localparam int DUMMY_BYTES = 1;
	localparam int LW          = $clog2(FIFO_DEPTH) + 1;
	localparam int MAX_BAUD    = 5;
	// worst case burst with every op counted as a full single lane byte
	localparam int IDLE_TIMEOUT = (2 + ADDR_BYTES + DUMMY_BYTES + FIFO_DEPTH + HANGUP_GAPS) *
		(8 * 4 * (MAX_BAUD + 1) + 2);

	logic                    clk;
	logic                    rst_n;
	logic [15:0]             bauddiv;
	logic [7:0]              data_in;
	logic                    data_push;
	logic                    data_pop;
	logic                    write_cmd;
	logic                    read_cmd;
	logic [8*ADDR_BYTES-1:0] address;
	logic [LW-1:0]           read_len;
	logic [7:0]              data_out;
	logic                    data_empty;
	logic                    busy;
	logic                    sck;
	logic                    cs_n;
	wire  [3:0]              sio;

	logic                    model_quad;
	int                      model_spi_bytes;
	logic [7:0]              model_spi_byte;
	int                      model_bursts;
	int                      model_wr_len;
	logic                    model_error;

	logic [7:0]              shadow [65536];        // expected device contents
	logic [31:0]             rng;
	logic [15:0]             rd_base;               // address of the burst being popped
	int                      rd_start;              // pops_seen when that burst began
	int                      pops_seen;             // accepted pops as counted by the checker

	tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(10)) u_clk (.clk(clk), .rst_n(rst_n));

	qspi_sram_ctrl #(
		.FIFO_DEPTH  (FIFO_DEPTH),
		.ADDR_BYTES  (ADDR_BYTES),
		.DUMMY_BYTES (DUMMY_BYTES)
	) u_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.bauddiv    (bauddiv),
		.data_in    (data_in),
		.data_push  (data_push),
		.data_pop   (data_pop),
		.write_cmd  (write_cmd),
		.read_cmd   (read_cmd),
		.address    (address),
		.read_len   (read_len),
		.data_out   (data_out),
		.data_empty (data_empty),
		.busy       (busy),
		.sck        (sck),
		.cs_n       (cs_n),
		.sio        (sio)
	);

	qspi_sram_model u_mem (
		.sck       (sck),
		.cs_n      (cs_n),
		.sio       (sio),
		.quad_mode (model_quad),
		.spi_bytes (model_spi_bytes),
		.spi_byte  (model_spi_byte),
		.bursts    (model_bursts),
		.write_len (model_wr_len),
		.error     (model_error)
	);

	for (genvar i = 0; i < 4; i++) begin : g_pull
		pullup (sio[i]);                            // idle lanes read high
	end

	task automatic report_error(input string what);
		$display("%s", what);
		$display("RESULT: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// device byte at offset from a burst start with the address wrapping at 64 KiB
	function automatic logic [7:0] ref_byte(input logic [15:0] base, input int offset);
		return shadow[16'(base + offset)];
	endfunction

	task automatic step();
		@(posedge clk);
		#2;                                         // inputs move just after the edge
	endtask

	task automatic wait_reset();
		int cycles;
		cycles = 0;
		while (rst_n !== 1'b1) begin
			@(negedge clk);
			cycles++;
			assert (cycles < 100) else report_error("reset was never released");
		end
		step();
	endtask

	task automatic wait_idle();
		int cycles;
		cycles = 0;
		while (busy !== 1'b0) begin
			step();
			cycles++;
			assert (cycles < IDLE_TIMEOUT) else report_error("timed out waiting for busy to fall");
		end
	endtask

	// pushes, pops and commands that a busy controller must ignore
	task automatic poke_while_busy();
		assert (busy) else report_error("burst ended before the busy pokes");
		data_in   = 8'hee;
		data_push = 1'b1;
		read_cmd  = 1'b1;
		read_len  = LW'(1);
		address   = 16'h1234;
		step();
		read_cmd  = 1'b0;
		write_cmd = 1'b1;
		step();
		write_cmd = 1'b0;
		data_push = 1'b0;
		data_pop  = 1'b1;                           // checker skips pops while busy
		step();
		data_pop  = 1'b0;
		assert (busy) else report_error("burst ended during the busy pokes");
	endtask

	task automatic write_burst(input logic [15:0] addr, input int n);
		int kept;
		int bursts_before;
		kept = (n > FIFO_DEPTH) ? FIFO_DEPTH : n;   // the rest hits a full buffer
		assert (data_empty) else report_error("buffer not empty before a write");
		for (int i = 0; i < n; i++) begin
			rng       = xorshift32(rng);
			data_in   = rng[7:0];
			data_push = 1'b1;
			if (i < FIFO_DEPTH) begin
				shadow[16'(addr + i)] = rng[7:0];
			end
			step();
		end
		data_push     = 1'b0;
		bursts_before = model_bursts;
		address       = addr;
		write_cmd     = 1'b1;
		step();
		write_cmd = 1'b0;
		poke_while_busy();
		wait_idle();
		assert (model_bursts == bursts_before + 1)
			else report_error($sformatf("Mismatch model_bursts expected %h actual %h",
				bursts_before + 1, model_bursts));
		assert (model_wr_len == kept)
			else report_error($sformatf("Mismatch model_wr_len expected %h actual %h",
				kept, model_wr_len));
		assert (data_empty) else report_error("buffer not drained by the write burst");
	endtask

	task automatic read_burst(input logic [15:0] addr, input int n);
		int          bursts_before;
		logic [7:0]  held;
		bursts_before = model_bursts;
		address       = addr;
		read_len      = LW'(n);
		read_cmd      = 1'b1;
		step();
		read_cmd = 1'b0;
		poke_while_busy();
		wait_idle();
		assert (model_bursts == bursts_before + 1)
			else report_error($sformatf("Mismatch model_bursts expected %h actual %h",
				bursts_before + 1, model_bursts));
		rd_base  = addr;
		rd_start = pops_seen;
		for (int i = 0; i < n; i++) begin
			assert (!data_empty)
				else report_error($sformatf("buffer ran empty after %0d of %0d bytes", i, n));
			data_pop = 1'b1;
			step();
		end
		data_pop = 1'b0;
		assert (data_empty) else report_error("buffer still holds data after the last pop");
		held     = data_out;
		data_pop = 1'b1;                            // pop while empty
		step();
		data_pop = 1'b0;
		step();
		assert (data_out === held)
			else report_error($sformatf("Mismatch data_out expected %h actual %h",
				held, data_out));
	endtask

	// compares every accepted pop with the shadow
	always @(negedge clk) begin : compare
		logic [7:0] expected;
		if (rst_n && busy === 1'b0 && data_pop && !data_empty) begin
			expected = ref_byte(rd_base, pops_seen - rd_start);
			assert (data_out === expected)
				else report_error($sformatf("Mismatch data_out expected %h actual %h",
					expected, data_out));
			pops_seen++;
		end
	end

	// bus must be parked whenever the controller is idle
	always @(negedge clk) begin : idle_watch
		if (rst_n && busy === 1'b0) begin
			assert (sck === 1'b0)
				else report_error($sformatf("Mismatch sck expected %h actual %h", 1'b0, sck));
			assert (cs_n === 1'b1)
				else report_error($sformatf("Mismatch cs_n expected %h actual %h", 1'b1, cs_n));
			assert (sio === 4'hf)
				else report_error($sformatf("Mismatch sio expected %h actual %h", 4'hf, sio));
		end
		assert (model_error !== 1'b1) else report_error("memory model saw an illegal transfer");
	end

	initial begin
		int          bauds [3];
		logic [15:0] a;
		int          n;
		bauds     = '{0, 1, MAX_BAUD};
		bauddiv   = 16'd1;
		data_in   = 8'h00;
		data_push = 1'b0;
		data_pop  = 1'b0;
		write_cmd = 1'b0;
		read_cmd  = 1'b0;
		address   = '0;
		read_len  = '0;
		rd_base   = 16'h0000;
		rd_start  = 0;
		pops_seen = 0;
		rng       = 32'h8c99_dad8;

		wait_reset();
		wait_idle();                                // init sequence
		assert (model_spi_bytes == 1)
			else report_error($sformatf("Mismatch model_spi_bytes expected %h actual %h",
				1, model_spi_bytes));
		assert (model_spi_byte == CMD_QUAD_ENTER)
			else report_error($sformatf("Mismatch model_spi_byte expected %h actual %h",
				CMD_QUAD_ENTER, model_spi_byte));
		assert (model_quad) else report_error("memory model never entered quad mode");

		bauddiv = 16'd0;
		write_burst(16'hfff0, FIFO_DEPTH);          // crosses 0xffff
		read_burst(16'hfff0, FIFO_DEPTH);
		read_burst(16'hfff8, 1);
		rng = xorshift32(rng);
		a   = rng[31:16];
		write_burst(a, FIFO_DEPTH + 8);             // overflow pushes dropped
		read_burst(a, FIFO_DEPTH);

		foreach (bauds[b]) begin
			bauddiv = 16'(bauds[b]);
			read_burst(16'hfff0, FIFO_DEPTH);       // same data at every rate
			for (int r = 0; r < 4; r++) begin
				rng = xorshift32(rng);
				a   = rng[31:16];
				n   = 1 + int'(rng[4:0]);
				write_burst(a, n);
				read_burst(a, n);
			end
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== verilog.f ====
verilog/qspi_sram_pkg.sv
verilog/burst_buffer.sv
verilog/sram_sequencer.sv
verilog/qspi_phy.sv
verilog/qspi_sram_ctrl.sv
verif/tb_clock_gen.sv
verif/qspi_sram_model.sv
verif/tb_qspi_sram.sv

// ==== Makefile ====
TOP := tb_qspi_sram
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		-f verilog.f --top-module $(TOP) -Mdir $(OBJ) -o V$(TOP)

# exit status of the simulation is the pass or fail result
run: compile
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)
